// File: rtl/spi_bus_pkg.sv
`default_nettype none

package spi_bus_pkg;

   // width of every word in the transmit and receive queues
   localparam int DATA_WIDTH = 32;

   typedef enum logic {
      SEL_ONEHOT,
      SEL_BINARY
   } sel_mode_e;

   typedef logic [7:0] delay_t;  // start, select and tail delays

endpackage

`default_nettype wire

// File: rtl/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

   typedef struct packed {
      logic [3:0] id;
      logic [2:0] device;
      logic       cpol;
      logic       cpha;
      logic [5:0] xfer_len;     // number of bits, 1 to 32
      logic [3:0] sclk_cycles;  // half period minus one
      logic [7:0] wait_start;
      logic [3:0] csn_to_sclk;
      logic [3:0] sclk_to_csn;
      logic [4:0] rsvd;
   } spi_cmd_t;

   localparam int CMD_WIDTH = $bits(spi_cmd_t);

   typedef struct packed {
      logic [7:0] magic;
      logic [3:0] id;
   } spi_resp_t;

   localparam logic [7:0] RESP_MAGIC = 8'hA5;

   // the second word of every transfer is a response, the first one raw data
   typedef union packed {
      struct packed {
         spi_resp_t resp;
         logic [spi_bus_pkg::DATA_WIDTH-$bits(spi_resp_t)-1:0] pad;
      } r;
      logic [spi_bus_pkg::DATA_WIDTH-1:0] data;
   } spi_resp_u;

endpackage

`default_nettype wire

// File: rtl/spi_cmd_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                  cmds_in,
   input  logic                  rst_n,
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   input  spi_cmd_pkg::spi_cmd_t cmd,
   output logic                  out_valid,
   input  logic                  out_ready,
   output spi_cmd_pkg::spi_cmd_t out_cmd
);
   import spi_cmd_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [CMD_WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [CNT_W-1:0]     count;
   logic [CNT_W-1:0]     count_nxt;
   logic                 push;
   logic                 pop;

   assign push      = cmd_valid & cmd_ready;
   assign pop       = out_valid & out_ready;
   assign out_valid = (count != '0);
   assign out_cmd   = spi_cmd_t'(mem[rd_ptr]);
   assign count_nxt = count + CNT_W'(push) - CNT_W'(pop);

   always_ff @(posedge cmds_in or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         cmd_ready <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count     <= count_nxt;
         cmd_ready <= (count_nxt != CNT_W'(DEPTH));  // registered so it stays low in reset
      end
   end

   always_ff @(posedge cmds_in) begin
      if (push) begin
         mem[wr_ptr] <= cmd;
      end
   end

endmodule

`default_nettype wire

// File: rtl/spi_data_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module spi_data_fifo #(
   parameter int DEPTH = 8
) (
   input  logic                                cmds_in,
   input  logic                                rst_n,
   input  logic                                in_valid,
   output logic                                in_ready,
   input  logic [spi_bus_pkg::DATA_WIDTH-1:0]  in_data,
   output logic                                out_valid,
   input  logic                                out_ready,
   output logic [spi_bus_pkg::DATA_WIDTH-1:0]  out_data,
   output logic [7:0]                          free_slots
);
   import spi_bus_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [DATA_WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [CNT_W-1:0]      count;
   logic [CNT_W-1:0]      count_nxt;
   logic                  push;
   logic                  pop;

   assign push       = in_valid & in_ready;
   assign pop        = out_valid & out_ready;
   assign out_valid  = (count != '0);
   assign out_data   = mem[rd_ptr];
   assign count_nxt  = count + CNT_W'(push) - CNT_W'(pop);
   assign free_slots = 8'(CNT_W'(DEPTH) - count);

   always_ff @(posedge cmds_in or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         in_ready <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count    <= count_nxt;
         in_ready <= (count_nxt != CNT_W'(DEPTH));
      end
   end

   always_ff @(posedge cmds_in) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

endmodule

`default_nettype wire

// File: rtl/spi_state_timer.sv
`timescale 1ns/100ps
`default_nettype none

module spi_state_timer (
   input  logic                cmds_in,
   input  logic                rst_n,
   input  logic                state_change,
   input  spi_bus_pkg::delay_t load_value,
   output logic                expired
);
   import spi_bus_pkg::*;

   delay_t cnt;

   // a state entered with load_value N sees expired after N more cycles
   assign expired = (cnt == '0);

   always_ff @(posedge cmds_in or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (state_change) begin
         cnt <= load_value;
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/spi_shift_engine.sv
`timescale 1ns/100ps
`default_nettype none

module spi_shift_engine #(
   parameter spi_bus_pkg::sel_mode_e SEL_MODE  = spi_bus_pkg::SEL_ONEHOT,
   parameter int                     SEL_WIDTH = 8
) (
   input  logic                                cmds_in,
   input  logic                                rst_n,
   input  logic                                cmd_valid,
   output logic                                cmd_ready,
   input  spi_cmd_pkg::spi_cmd_t               cmd,
   input  logic                                tx_valid,
   output logic                                tx_ready,
   input  logic [spi_bus_pkg::DATA_WIDTH-1:0]  tx_data,
   output logic                                rx_valid,
   input  logic                                rx_ready,
   output logic [spi_bus_pkg::DATA_WIDTH-1:0]  rx_data,
   input  logic [7:0]                          rx_free,
   output logic                                cmd_completed,
   output logic                                engine_busy,
   output logic                                sclk,
   output logic                                mosi,
   input  logic                                miso,
   output logic [SEL_WIDTH-1:0]                sel,
   output logic                                sel_active
);
   import spi_bus_pkg::*;
   import spi_cmd_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      WAIT_BEGIN,
      SELECT,
      LATCH,
      SHIFT,
      DESELECT,
      WAIT_END,
      END
   } state_t;

   state_t                state;
   state_t                state_nxt;
   spi_cmd_t              cur_cmd;
   spi_cmd_t              act_cmd;
   spi_resp_u             resp_word;
   delay_t                load_value;
   logic                  state_change;
   logic                  expired;
   logic                  accept;
   logic                  half_end;
   logic                  sel_window;
   logic [SEL_WIDTH-1:0]  gen_sel;
   logic [5:0]            tx_shift;
   logic [5:0]            bits_left;
   logic [3:0]            sclk_cnt;
   logic                  sclk_gen;
   logic [DATA_WIDTH-1:0] tx_sreg;
   logic [DATA_WIDTH-1:0] rx_sreg;

   // two receive slots must be free so the data and response pushes never stall
   assign accept    = (state == IDLE) & cmd_valid & tx_valid & (rx_free >= 8'd2);
   assign cmd_ready = accept;
   assign tx_ready  = accept;

   assign act_cmd  = (state == IDLE) ? cmd : cur_cmd;  // the incoming command while idle
   assign gen_sel  = (SEL_MODE == SEL_ONEHOT) ? SEL_WIDTH'(1) << act_cmd.device
                                              : SEL_WIDTH'(act_cmd.device);
   assign tx_shift = 6'(DATA_WIDTH) - cmd.xfer_len;
   assign half_end = (sclk_cnt == '0);

   assign sclk          = sclk_gen ^ cur_cmd.cpol;
   assign mosi          = tx_sreg[DATA_WIDTH-1];
   assign engine_busy   = (state != IDLE);
   assign cmd_completed = (state == WAIT_END);
   assign rx_valid      = (state == WAIT_END) || (state == END);
   assign rx_data       = (state == END) ? resp_word.data : rx_sreg;

   always_comb begin
      resp_word.r.pad        = '0;
      resp_word.r.resp.magic = RESP_MAGIC;
      resp_word.r.resp.id    = cur_cmd.id;
   end

   always_comb begin
      state_nxt  = state;
      load_value = '0;
      case (state)
         IDLE: begin
            if (accept && act_cmd.wait_start != '0) begin
               state_nxt  = WAIT_BEGIN;
               load_value = act_cmd.wait_start - 1'b1;
            end else if (accept) begin
               state_nxt  = SELECT;
               load_value = delay_t'(act_cmd.csn_to_sclk);
            end
         end
         WAIT_BEGIN: begin
            if (expired) begin
               state_nxt  = SELECT;
               load_value = delay_t'(act_cmd.csn_to_sclk);
            end
         end
         SELECT:   if (expired) state_nxt = LATCH;
         LATCH:    if (half_end) state_nxt = SHIFT;
         SHIFT: begin
            if (half_end && bits_left == '0) begin
               state_nxt  = DESELECT;
               load_value = delay_t'(act_cmd.sclk_to_csn);
            end else if (half_end) begin
               state_nxt = LATCH;
            end
         end
         DESELECT: if (expired) state_nxt = WAIT_END;
         WAIT_END: if (rx_ready) state_nxt = END;      // received bits leave here
         END:      if (rx_ready) state_nxt = IDLE;     // response word leaves here
         default:  state_nxt = IDLE;
      endcase
   end

   assign state_change = (state_nxt != state);
   assign sel_window   = state_nxt inside {SELECT, LATCH, SHIFT, DESELECT};

   spi_state_timer state_timer_i (
      .cmds_in      (cmds_in),
      .rst_n        (rst_n),
      .state_change (state_change),
      .load_value   (load_value),
      .expired      (expired)
   );

   // LATCH is every odd half period and ends on a sampling edge, SHIFT every even one
   always_ff @(posedge cmds_in or negedge rst_n) begin
      if (!rst_n) begin
         state      <= IDLE;
         cur_cmd    <= '0;
         sclk_gen   <= 1'b0;
         sclk_cnt   <= '0;
         bits_left  <= '0;
         tx_sreg    <= '0;
         sel        <= '0;
         sel_active <= 1'b0;
      end else begin
         state      <= state_nxt;
         sel_active <= sel_window;
         sel        <= sel_window ? gen_sel : '0;
         case (state)
            IDLE: begin
               if (accept) begin
                  cur_cmd   <= cmd;
                  bits_left <= cmd.xfer_len;
                  tx_sreg   <= tx_data << tx_shift;  // bit xfer_len-1 goes out first
               end
            end
            SELECT: begin
               if (expired) begin
                  sclk_gen <= sclk_gen ^ cur_cmd.cpha;  // cpha 1 has its leading edge here
                  sclk_cnt <= cur_cmd.sclk_cycles;
               end
            end
            LATCH: begin
               if (half_end) begin
                  sclk_gen  <= ~sclk_gen;
                  sclk_cnt  <= cur_cmd.sclk_cycles;
                  bits_left <= bits_left - 1'b1;
               end else begin
                  sclk_cnt <= sclk_cnt - 1'b1;
               end
            end
            SHIFT: begin
               if (half_end && bits_left == '0) begin
                  sclk_gen <= sclk_gen ^ ~cur_cmd.cpha;  // cpha 0 ends on a trailing edge
               end else if (half_end) begin
                  sclk_gen <= ~sclk_gen;
                  sclk_cnt <= cur_cmd.sclk_cycles;
                  tx_sreg  <= tx_sreg << 1;
               end else begin
                  sclk_cnt <= sclk_cnt - 1'b1;
               end
            end
            default: begin
            end
         endcase
      end
   end

   always_ff @(posedge cmds_in) begin
      if (accept) begin
         rx_sreg <= '0;
      end else if (state == LATCH && half_end) begin
         rx_sreg <= {rx_sreg[DATA_WIDTH-2:0], miso};  // ends up right aligned
      end
   end

endmodule

`default_nettype wire

// File: rtl/spi_fifo_engine.sv
`timescale 1ns/100ps
`default_nettype none

module spi_fifo_engine #(
   parameter spi_bus_pkg::sel_mode_e SEL_MODE   = spi_bus_pkg::SEL_ONEHOT,
   parameter int                     SEL_WIDTH  = 8,
   parameter int                     CMD_DEPTH  = 4,
   parameter int                     DATA_DEPTH = 8
) (
   input  logic                                cmds_in,
   input  logic                                rst_n,
   input  logic                                cmd_valid,
   output logic                                cmd_ready,
   input  spi_cmd_pkg::spi_cmd_t               cmd,
   input  logic                                tx_valid,
   output logic                                tx_ready,
   input  logic [spi_bus_pkg::DATA_WIDTH-1:0]  tx_data,
   output logic                                rx_valid,
   input  logic                                rx_ready,
   output logic [spi_bus_pkg::DATA_WIDTH-1:0]  rx_data,
   output logic                                cmd_completed,
   output logic                                engine_busy,
   output logic                                sclk,
   output logic                                mosi,
   input  logic                                miso,
   output logic [SEL_WIDTH-1:0]                sel,
   output logic                                sel_active
);
   import spi_bus_pkg::*;
   import spi_cmd_pkg::*;

   logic                  eng_cmd_valid;
   logic                  eng_cmd_ready;
   spi_cmd_t              eng_cmd;
   logic                  eng_tx_valid;
   logic                  eng_tx_ready;
   logic [DATA_WIDTH-1:0] eng_tx_data;
   logic                  eng_rx_valid;
   logic                  eng_rx_ready;
   logic [DATA_WIDTH-1:0] eng_rx_data;
   logic [7:0]            rx_free;

   spi_cmd_fifo #(
      .DEPTH (CMD_DEPTH)
   ) cmd_fifo_i (
      .cmds_in   (cmds_in),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd       (cmd),
      .out_valid (eng_cmd_valid),
      .out_ready (eng_cmd_ready),
      .out_cmd   (eng_cmd)
   );

   spi_data_fifo #(
      .DEPTH (DATA_DEPTH)
   ) tx_fifo_i (
      .cmds_in    (cmds_in),
      .rst_n      (rst_n),
      .in_valid   (tx_valid),
      .in_ready   (tx_ready),
      .in_data    (tx_data),
      .out_valid  (eng_tx_valid),
      .out_ready  (eng_tx_ready),
      .out_data   (eng_tx_data),
      .free_slots ()  // the host sees room through tx_ready
   );

   spi_data_fifo #(
      .DEPTH (DATA_DEPTH)
   ) rx_fifo_i (
      .cmds_in    (cmds_in),
      .rst_n      (rst_n),
      .in_valid   (eng_rx_valid),
      .in_ready   (eng_rx_ready),
      .in_data    (eng_rx_data),
      .out_valid  (rx_valid),
      .out_ready  (rx_ready),
      .out_data   (rx_data),
      .free_slots (rx_free)
   );

   spi_shift_engine #(
      .SEL_MODE  (SEL_MODE),
      .SEL_WIDTH (SEL_WIDTH)
   ) engine_i (
      .cmds_in       (cmds_in),
      .rst_n         (rst_n),
      .cmd_valid     (eng_cmd_valid),
      .cmd_ready     (eng_cmd_ready),
      .cmd           (eng_cmd),
      .tx_valid      (eng_tx_valid),
      .tx_ready      (eng_tx_ready),
      .tx_data       (eng_tx_data),
      .rx_valid      (eng_rx_valid),
      .rx_ready      (eng_rx_ready),
      .rx_data       (eng_rx_data),
      .rx_free       (rx_free),
      .cmd_completed (cmd_completed),
      .engine_busy   (engine_busy),
      .sclk          (sclk),
      .mosi          (mosi),
      .miso          (miso),
      .sel           (sel),
      .sel_active    (sel_active)
   );

endmodule

`default_nettype wire

// File: tb/spi_tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module spi_tb_clock #(
   parameter int HALF_PERIOD  = 20,
   parameter int RESET_CYCLES = 16
) (
   output logic cmds_in,
   output logic rst_n
);

   initial begin
      cmds_in = 1'b0;
      forever #(HALF_PERIOD) cmds_in = ~cmds_in;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge cmds_in);
      @(negedge cmds_in);
      rst_n = 1'b1;  // released away from the active edge
   end

endmodule

`default_nettype wire

// File: tb/spi_fifo_engine_tb.sv
`timescale 1ns/100ps
`default_nettype none

module spi_fifo_engine_tb;
   import spi_bus_pkg::*;
   import spi_cmd_pkg::*;

   localparam int NUM_ROWS   = 12;
   localparam int NUM_SINGLE = 6;  // rows sent one at a time, the others are queued

   typedef struct packed {
      spi_cmd_t              cmd;
      logic [DATA_WIDTH-1:0] tx;
      logic [DATA_WIDTH-1:0] exp_rx;
      logic [7:0]            exp_sel;
   } row_t;

   logic                  cmds_in;
   logic                  rst_n;
   logic                  cmd_valid;
   logic                  cmd_ready;
   spi_cmd_t              cmd;
   logic                  tx_valid;
   logic                  tx_ready;
   logic [DATA_WIDTH-1:0] tx_data;
   logic                  rx_valid;
   logic                  rx_ready;
   logic [DATA_WIDTH-1:0] rx_data;
   logic                  cmd_completed;
   logic                  engine_busy;
   logic                  sclk;
   logic                  mosi;
   logic                  miso;
   logic [7:0]            sel;
   logic                  sel_active;

   row_t      rows [NUM_ROWS];
   spi_resp_u resp_word;
   int        seed = 72;
   int        checks = 0;
   int        errors = 0;
   int        timeouts = 0;
   int        cycles = 0;
   int        cycle_limit = 100000;
   int        xfer_idx = 0;
   int        rx_idx = 0;
   int        lead_edges = 0;
   bit        resp_next = 1'b0;
   logic      sel_prev = 1'b0;
   logic      sclk_prev = 1'b0;

   assign miso = mosi;  // every transfer reads back what it sends

   spi_tb_clock clock_i (
      .cmds_in (cmds_in),
      .rst_n   (rst_n)
   );

   spi_fifo_engine #(
      .SEL_MODE   (SEL_ONEHOT),
      .SEL_WIDTH  (8),
      .CMD_DEPTH  (4),
      .DATA_DEPTH (8)
   ) dut_i (
      .cmds_in       (cmds_in),
      .rst_n         (rst_n),
      .cmd_valid     (cmd_valid),
      .cmd_ready     (cmd_ready),
      .cmd           (cmd),
      .tx_valid      (tx_valid),
      .tx_ready      (tx_ready),
      .tx_data       (tx_data),
      .rx_valid      (rx_valid),
      .rx_ready      (rx_ready),
      .rx_data       (rx_data),
      .cmd_completed (cmd_completed),
      .engine_busy   (engine_busy),
      .sclk          (sclk),
      .mosi          (mosi),
      .miso          (miso),
      .sel           (sel),
      .sel_active    (sel_active)
   );

   function automatic row_t make_row(input logic [3:0] id, input logic [2:0] device,
                                     input logic cpol, input logic cpha,
                                     input logic [5:0] len, input logic [3:0] half,
                                     input logic [7:0] wait_start, input logic [3:0] lead,
                                     input logic [3:0] tail, input logic [DATA_WIDTH-1:0] tx);
      row_t        r;
      logic [63:0] mask;
      mask = (64'd1 << len) - 64'd1;
      r = '0;
      r.cmd.id          = id;
      r.cmd.device      = device;
      r.cmd.cpol        = cpol;
      r.cmd.cpha        = cpha;
      r.cmd.xfer_len    = len;
      r.cmd.sclk_cycles = half;
      r.cmd.wait_start  = wait_start;
      r.cmd.csn_to_sclk = lead;
      r.cmd.sclk_to_csn = tail;
      r.tx      = tx;
      r.exp_rx  = tx & mask[DATA_WIDTH-1:0];
      r.exp_sel = 8'd1 << device;
      return r;
   endfunction

   // start delay, select lead, all half periods, tail and the two receive pushes
   function automatic int row_cycles(input row_t r);
      return int'(r.cmd.wait_start) + int'(r.cmd.csn_to_sclk) + 1
             + 2 * int'(r.cmd.xfer_len) * (int'(r.cmd.sclk_cycles) + 1)
             + int'(r.cmd.sclk_to_csn) + 1 + 2;
   endfunction

   task automatic verify(input bit ok, input string msg);
      checks++;
      assert (ok) else begin
         $display("FAILED at %0t ns: %s", $time, msg);
         errors++;
      end
   endtask

   task automatic check_idle_outputs(input string when);
      verify(!sclk && sel == '0 && !sel_active && !engine_busy && !cmd_completed && !rx_valid,
             $sformatf("%s: sclk %b sel %h sel_active %b busy %b completed %b rx_valid %b",
                       when, sclk, sel, sel_active, engine_busy, cmd_completed, rx_valid));
   endtask

   task automatic push_row(input int i);
      @(negedge cmds_in);
      cmd_valid = 1'b1;
      cmd       = rows[i].cmd;
      while (!cmd_ready) @(negedge cmds_in);
      @(negedge cmds_in);
      cmd_valid = 1'b0;
      tx_valid  = 1'b1;
      tx_data   = rows[i].tx;
      while (!tx_ready) @(negedge cmds_in);
      @(negedge cmds_in);
      tx_valid = 1'b0;
   endtask

   task automatic wait_rx(input int n);
      while (rx_idx < n) @(negedge cmds_in);
   endtask

   task automatic finish_run();
      $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   endtask

   // select, sclk level and sclk leading edges of the transfer in progress
   always @(negedge cmds_in) begin
      if (rst_n === 1'b1 && xfer_idx < NUM_ROWS) begin
         if (sel_active && !sel_prev) begin
            lead_edges = 0;
            verify(sclk == rows[xfer_idx].cmd.cpol,
                   $sformatf("row %0d: sclk not at idle level when select rises", xfer_idx));
         end
         if (sel_active) begin
            verify(sel == rows[xfer_idx].exp_sel,
                   $sformatf("row %0d: sel %h, expected %h", xfer_idx, sel,
                             rows[xfer_idx].exp_sel));
            if (sel_prev && sclk_prev == rows[xfer_idx].cmd.cpol
                && sclk != rows[xfer_idx].cmd.cpol) begin
               lead_edges++;
            end
         end
         if (cmd_completed) begin
            verify(sclk == rows[xfer_idx].cmd.cpol
                   && lead_edges == int'(rows[xfer_idx].cmd.xfer_len),
                   $sformatf("row %0d: sclk %b at end, %0d leading edges", xfer_idx, sclk,
                             lead_edges));
            xfer_idx++;
         end
      end
      sel_prev  = sel_active;
      sclk_prev = sclk;
   end

   // words are taken where valid and ready meet at the rising edge
   always @(posedge cmds_in) begin
      if (rst_n === 1'b1 && rx_valid && rx_ready) begin
         if (rx_idx >= NUM_ROWS) begin
            verify(1'b0, "a receive word arrived after the last expected one");
         end else if (!resp_next) begin
            verify(rx_data == rows[rx_idx].exp_rx,
                   $sformatf("row %0d: rx data %h, expected %h", rx_idx, rx_data,
                             rows[rx_idx].exp_rx));
            resp_next = 1'b1;
         end else begin
            resp_word.data = rx_data;
            verify(resp_word.r.resp.magic == RESP_MAGIC && resp_word.r.pad == '0
                   && resp_word.r.resp.id == rows[rx_idx].cmd.id,
                   $sformatf("row %0d: response %h, expected id %h", rx_idx, rx_data,
                             rows[rx_idx].cmd.id));
            resp_next = 1'b0;
            rx_idx++;
         end
      end
   end

   always @(posedge cmds_in) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("ERROR: the test did not end within %0d cycles and was stopped", cycle_limit);
         timeouts++;
         finish_run();
      end
   end

   initial begin
      int limit;
      cmd_valid = 1'b0;
      cmd       = '0;
      tx_valid  = 1'b0;
      tx_data   = '0;
      rx_ready  = 1'b0;
      rows[0]  = make_row(4'd1, 3'd0, 1'b0, 1'b0, 6'd8, 4'd1, 8'd3, 4'd2, 4'd1, 32'h0000_00a5);
      rows[1]  = make_row(4'd2, 3'd3, 1'b0, 1'b1, 6'd1, 4'd0, 8'd0, 4'd0, 4'd0, 32'hffff_ffff);
      rows[2]  = make_row(4'd3, 3'd5, 1'b1, 1'b0, 6'd32, 4'd0, 8'd2, 4'd1, 4'd2, 32'hdead_beef);
      rows[3]  = make_row(4'd4, 3'd7, 1'b1, 1'b1, 6'd8, 4'd2, 8'd1, 4'd3, 4'd0, $random(seed));
      rows[4]  = make_row(4'd5, 3'd1, 1'b0, 1'b0, 6'd32, 4'd0, 8'd0, 4'd0, 4'd0, $random(seed));
      rows[5]  = make_row(4'd6, 3'd2, 1'b1, 1'b1, 6'd1, 4'd3, 8'd5, 4'd1, 4'd1, $random(seed));
      rows[6]  = make_row(4'd7, 3'd4, 1'b0, 1'b0, 6'd16, 4'd0, 8'd0, 4'd0, 4'd0, $random(seed));
      rows[7]  = make_row(4'd8, 3'd6, 1'b1, 1'b0, 6'd12, 4'd1, 8'd1, 4'd0, 4'd1, $random(seed));
      rows[8]  = make_row(4'd9, 3'd0, 1'b0, 1'b1, 6'd32, 4'd0, 8'd0, 4'd1, 4'd0, $random(seed));
      rows[9]  = make_row(4'd10, 3'd2, 1'b1, 1'b1, 6'd5, 4'd0, 8'd2, 4'd0, 4'd0, $random(seed));
      rows[10] = make_row(4'd11, 3'd1, 1'b0, 1'b0, 6'd8, 4'd1, 8'd0, 4'd0, 4'd0, $random(seed));
      rows[11] = make_row(4'd12, 3'd7, 1'b1, 1'b0, 6'd24, 4'd0, 8'd1, 4'd2, 4'd1, $random(seed));
      limit = 20;
      foreach (rows[i]) begin
         limit += row_cycles(rows[i]) + 10;  // plus host handshakes
      end
      cycle_limit = limit + 30 + 100;

      @(posedge cmds_in);
      repeat (4) begin
         @(negedge cmds_in);
         check_idle_outputs("during reset");
         verify(!cmd_ready && !tx_ready,
                $sformatf("during reset: cmd_ready %b tx_ready %b", cmd_ready, tx_ready));
      end
      wait (rst_n === 1'b1);
      @(negedge cmds_in);
      check_idle_outputs("after reset");
      verify(cmd_ready && tx_ready,
             $sformatf("after reset: cmd_ready %b tx_ready %b", cmd_ready, tx_ready));

      rx_ready = 1'b1;
      for (int i = 0; i < NUM_SINGLE; i++) begin
         push_row(i);
         wait_rx(i + 1);
      end

      // queue the rest with the host not reading, four transfers fill the receive queue
      @(negedge cmds_in);
      rx_ready = 1'b0;
      for (int i = NUM_SINGLE; i < NUM_ROWS; i++) begin
         push_row(i);
      end
      while (xfer_idx < NUM_SINGLE + 4) @(negedge cmds_in);
      repeat (2) @(negedge cmds_in);
      repeat (20) begin
         @(negedge cmds_in);
         verify(!engine_busy, "engine started a transfer while the receive queue was full");
      end
      rx_ready = 1'b1;
      wait_rx(NUM_ROWS);
      repeat (4) @(negedge cmds_in);
      verify(xfer_idx == NUM_ROWS && !rx_valid,
             $sformatf("%0d of %0d transfers seen, rx_valid %b", xfer_idx, NUM_ROWS, rx_valid));
      finish_run();
   end

endmodule

`default_nettype wire

// File: filelist.f
rtl/spi_bus_pkg.sv
rtl/spi_cmd_pkg.sv
rtl/spi_cmd_fifo.sv
rtl/spi_data_fifo.sv
rtl/spi_state_timer.sv
rtl/spi_shift_engine.sv
rtl/spi_fifo_engine.sv
tb/spi_tb_clock.sv
tb/spi_fifo_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
top=spi_fifo_engine_tb

verilator --binary --timing --assert -Wno-fatal --top-module "$top" \
   -f filelist.f -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_bin > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
   exit 1
fi
exit 0
